/* common/fp_pkg.sv */
package fp_pkg;

    // binary32 field widths
    localparam int unsigned EXP_W = 8;
    localparam int unsigned FRAC_W = 23;
    localparam int unsigned SIG_W = FRAC_W + 1;
    localparam int unsigned SHAMT_W = 5;

    localparam int unsigned WB_ADDR_W = 5;
    localparam int unsigned WB_DATA_W = 32;

    typedef logic [EXP_W+FRAC_W:0] float32_t;
    typedef logic [EXP_W-1:0] fexp_t;
    typedef logic [FRAC_W-1:0] frac_t;
    typedef logic [SIG_W-1:0] sig_t;
    typedef logic [SHAMT_W-1:0] shamt_t;
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;

    // exponent of infinity
    localparam fexp_t EXP_MAX = '1;

    // leading zero counter split into 5 groups of 5 bits
    localparam int unsigned LZC_GRP_W = 5;
    localparam int unsigned LZC_N_GRP = 5;

    // register map, byte offsets
    localparam wb_addr_t REG_X = 5'h00;
    localparam wb_addr_t REG_Y = 5'h04;
    localparam wb_addr_t REG_CMD = 5'h08;
    localparam wb_addr_t REG_RES = 5'h0c;
    localparam wb_addr_t REG_STAT = 5'h10;

    // cycles from issue to res_valid
    localparam int unsigned FADD_LATENCY = 2;

endpackage

/* common/fadd_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface fadd_if import fp_pkg::*;;

    // one cycle strobe, operands sampled with it
    logic     issue;
    float32_t x;
    float32_t y;

    // sum, valid for one cycle FADD_LATENCY after issue
    logic     res_valid;
    float32_t res;

    modport master (
        output issue,
        output x,
        output y,
        input  res_valid,
        input  res
    );

    modport slave (
        input  issue,
        input  x,
        input  y,
        output res_valid,
        output res
    );

endinterface

`default_nettype wire

/* fadd/lzc.sv */
`timescale 1ns/10ps
`default_nettype none

module lzc import fp_pkg::*; (
    input  logic [SIG_W:0] x,
    output shamt_t         res
);

    logic [LZC_N_GRP-1:0] grp_any;
    logic [2:0]           grp_cnt [LZC_N_GRP];

    // first level: count inside each group, group 0 holds the msbs
    always_comb begin
        for (int g = 0; g < LZC_N_GRP; g++) begin
            grp_any[g] = 1'b0;
            grp_cnt[g] = 3'd0;
            for (int b = 0; b < LZC_GRP_W; b++) begin
                if (!grp_any[g] && x[SIG_W - g * LZC_GRP_W - b]) begin
                    grp_any[g] = 1'b1;
                    grp_cnt[g] = 3'(b);
                end
            end
        end
    end

    // second level: first nonzero group wins
    // all zero gives 25
    always_comb begin
        res = shamt_t'(LZC_N_GRP * LZC_GRP_W);
        for (int g = LZC_N_GRP - 1; g >= 0; g--) begin
            if (grp_any[g]) begin
                res = shamt_t'(g * LZC_GRP_W) + shamt_t'(grp_cnt[g]);
            end
        end
    end

endmodule

`default_nettype wire

/* fadd/fadd.sv */
`timescale 1ns/10ps
`default_nettype none

module fadd import fp_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    fadd_if.slave bus
);

    logic       sx;
    logic       sy;
    fexp_t      ex;
    fexp_t      ey;
    frac_t      mx;
    frac_t      my;
    logic [8:0] exy;
    logic [8:0] eyx;
    logic       x_bigger;
    fexp_t      eb;
    fexp_t      ediff;
    sig_t       mb_sup;
    sig_t       ms_sup;
    logic       s_big;
    logic       is_add;
    logic       is_close;

    logic [49:0] ms_wide;
    logic [26:0] ms_packed;
    logic [27:0] m_add;
    logic        far_udf;
    logic        far_ovf;
    logic        far_sign;
    fexp_t       far_exp;
    logic [24:0] far_sig;
    logic        far_sticky;

    logic [24:0] ms_close;
    logic [25:0] mxy;
    logic [25:0] myx;
    logic [24:0] m_abs;
    shamt_t      lz;
    logic [8:0]  e_norm;
    logic        close_udf;
    logic        close_sign;
    fexp_t       close_exp;
    logic [24:0] close_sig;

    logic        s1_valid;
    logic        s1_sign;
    fexp_t       s1_exp;
    logic [24:0] s1_sig;
    logic        s1_sticky;

    logic        round_up;
    logic [24:0] m_round;
    fexp_t       exp_res;
    frac_t       frac_res;

    assign {sx, ex, mx} = bus.x;
    assign {sy, ey, my} = bus.y;

    // swap so that eb is the larger exponent
    assign exy = {1'b0, ex} - {1'b0, ey};
    assign eyx = {1'b0, ey} - {1'b0, ex};
    assign x_bigger = !exy[8];
    assign eb = x_bigger ? ex : ey;
    assign ediff = x_bigger ? exy[7:0] : eyx[7:0];
    assign mb_sup = {1'b1, x_bigger ? mx : my};
    assign ms_sup = {1'b1, x_bigger ? my : mx};
    assign s_big = x_bigger ? sx : sy;
    assign is_add = sx == sy;
    assign is_close = !is_add && ediff[7:1] == 7'd0;

    // far path, small operand aligned to guard, round and sticky
    assign ms_wide = (ediff >= 8'd26) ? {26'd0, ms_sup} : {ms_sup, 26'd0} >> ediff;
    assign ms_packed = {ms_wide[49:24], |ms_wide[23:0]};
    assign m_add = is_add ? {1'b0, mb_sup, 3'b000} + {1'b0, ms_packed}
                          : {1'b0, mb_sup, 3'b000} - {1'b0, ms_packed};

    assign far_udf = (eb == 8'd1 && !m_add[27] && !m_add[26]) ||
                     (eb == 8'd0 && !m_add[27]);
    assign far_ovf = (eb == EXP_MAX && (m_add[27] || m_add[26])) ||
                     (eb == EXP_MAX - 8'd1 && m_add[27]);

    always_comb begin
        far_sign = s_big;
        if (m_add[27]) begin
            far_exp = eb + 8'd1;
            far_sig = m_add[27:3];
            far_sticky = |m_add[2:0];
        end else if (m_add[26]) begin
            far_exp = eb;
            far_sig = m_add[26:2];
            far_sticky = |m_add[1:0];
        end else begin
            // at most one bit of cancellation here
            far_exp = eb - 8'd1;
            far_sig = m_add[25:1];
            far_sticky = m_add[0];
        end
        if (far_udf) begin
            far_sign = 1'b0;
            far_exp = '0;
            far_sig = '0;
        end else if (far_ovf) begin
            far_exp = EXP_MAX;
            far_sig = '0;
        end
    end

    // close path, exponents differ by 0 or 1
    assign ms_close = (ediff != 8'd0) ? {1'b0, ms_sup} : {ms_sup, 1'b0};
    assign mxy = {1'b0, mb_sup, 1'b0} - {1'b0, ms_close};
    assign myx = {1'b0, ms_close} - {1'b0, mb_sup, 1'b0};
    assign m_abs = mxy[25] ? myx[24:0] : mxy[24:0];

    lzc i_lzc (
        .x   (m_abs),
        .res (lz)
    );

    // exact zero counts as underflow too
    assign e_norm = {1'b0, eb} - {4'b0000, lz};
    assign close_udf = e_norm[8] || e_norm == 9'd0 || lz == shamt_t'(SIG_W + 1);
    assign close_sign = close_udf ? 1'b0 : (mxy[25] ? !s_big : s_big);
    assign close_exp = close_udf ? '0 : e_norm[7:0];
    assign close_sig = close_udf ? '0 : m_abs << lz;

    // stage 1 registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= bus.issue;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.issue) begin
            s1_sign <= is_close ? close_sign : far_sign;
            s1_exp <= is_close ? close_exp : far_exp;
            s1_sig <= is_close ? close_sig : far_sig;
            s1_sticky <= is_close ? 1'b0 : far_sticky;
        end
    end

    // round to nearest even, s1_sig[0] is the guard bit
    assign round_up = s1_sig[0] && (s1_sticky || s1_sig[1]);
    assign m_round = {1'b0, s1_sig[24:1]} + {24'd0, round_up};
    assign exp_res = m_round[24] ? s1_exp + 8'd1 : s1_exp;
    assign frac_res = m_round[24] ? '0 : m_round[22:0];

    // stage 2 registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.res_valid <= 1'b0;
        end else begin
            bus.res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            bus.res <= {s1_sign, exp_res, frac_res};
        end
    end

endmodule

`default_nettype wire

/* src/fadd_wb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

// result returns FADD_LATENCY cycles after issue, reads of REG_RES wait for it
module fadd_wb_regs import fp_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_addr_t   wb_adr,
    input  wb_data_t   wb_dat_w,
    input  logic [3:0] wb_sel,
    output wb_data_t   wb_dat_r,
    output logic       wb_ack,
    fadd_if.master     core
);

    logic     req;
    logic     res_read;
    logic     stall;
    logic     accept;
    logic     wr_x;
    logic     wr_y;
    logic     wr_cmd;
    logic     busy;
    float32_t x_q;
    float32_t y_q;
    float32_t res_q;
    wb_data_t rd_mux;

    // operations in flight
    logic [$clog2(FADD_LATENCY + 2)-1:0] inflight;

    assign req = wb_cyc && wb_stb;
    assign res_read = !wb_we && wb_adr == REG_RES;
    assign stall = res_read && busy;
    assign accept = req && !wb_ack && !stall;

    assign wr_x = accept && wb_we && wb_adr == REG_X;
    assign wr_y = accept && wb_we && wb_adr == REG_Y;
    assign wr_cmd = accept && wb_we && wb_adr == REG_CMD;

    assign busy = inflight != '0;
    assign core.x = x_q;
    assign core.y = y_q;

    // single cycle ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
            core.issue <= 1'b0;
        end else begin
            wb_ack <= accept;
            core.issue <= wr_cmd;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inflight <= '0;
        end else begin
            case ({wr_cmd, core.res_valid})
                2'b10: inflight <= inflight + 1'b1;
                2'b01: inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    // byte lanes on the operand registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_q <= '0;
            y_q <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr_x && wb_sel[i]) begin
                    x_q[8*i +: 8] <= wb_dat_w[8*i +: 8];
                end
                if (wr_y && wb_sel[i]) begin
                    y_q[8*i +: 8] <= wb_dat_w[8*i +: 8];
                end
            end
        end
    end

    // last returned sum wins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_q <= '0;
        end else if (core.res_valid) begin
            res_q <= core.res;
        end
    end

    always_comb begin
        case (wb_adr)
            REG_X: rd_mux = x_q;
            REG_Y: rd_mux = y_q;
            REG_RES: rd_mux = res_q;
            REG_STAT: rd_mux = {31'd0, busy};
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept && !wb_we) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* src/fadd_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fadd_unit import fp_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_addr_t   wb_adr,
    input  wb_data_t   wb_dat_w,
    input  logic [3:0] wb_sel,
    output wb_data_t   wb_dat_r,
    output logic       wb_ack
);

    // register block to adder
    fadd_if i_fadd_if ();

    fadd_wb_regs i_fadd_wb_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .core     (i_fadd_if)
    );

    fadd i_fadd (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (i_fadd_if)
    );

endmodule

`default_nettype wire

/* bench/fadd_unit_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module fadd_unit_properties import fp_pkg::*; (
    input logic clk,
    input logic arst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic issue,
    input logic res_valid
);

    ack_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack
    ) else $error("wb_ack high for two cycles in a row");

    // ack only answers a live request
    ack_in_request: assert property (
        @(posedge clk) disable iff (!arst_n) wb_ack |-> wb_cyc && wb_stb
    ) else $error("wb_ack outside cyc and stb");

    issue_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) issue |=> !issue
    ) else $error("issue wider than one cycle");

    result_latency: assert property (
        @(posedge clk) disable iff (!arst_n) issue |-> ##FADD_LATENCY res_valid
    ) else $error("res_valid missing after issue");

    no_spurious_result: assert property (
        @(posedge clk) disable iff (!arst_n) res_valid |-> $past(issue, FADD_LATENCY)
    ) else $error("res_valid without a matching issue");

endmodule

bind fadd_wb_regs fadd_unit_properties i_fadd_unit_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .issue     (core.issue),
    .res_valid (core.res_valid)
);

`default_nettype wire

/* bench/fadd_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fadd_unit_tb import fp_pkg::*; ();

    localparam int unsigned ACK_TIMEOUT = 20;
    localparam int unsigned N_VEC = 15;

    logic       clk;
    logic       arst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    wb_data_t   wb_dat_w;
    logic [3:0] wb_sel;
    wb_data_t   wb_dat_r;
    logic       wb_ack;

    // each entry holds x, y and the expected sum
    logic [95:0] vectors [N_VEC] = '{
        {32'h3f800000, 32'h3f800000, 32'h40000000},
        {32'h3fc00000, 32'h40100000, 32'h40700000},
        {32'h40000000, 32'h3f800000, 32'h40400000},
        // 1 + 2^-24 is a tie that stays even
        {32'h3f800000, 32'h33800000, 32'h3f800000},
        // 1 + 1.5*2^-23 rounds up to even
        {32'h3f800000, 32'h34400000, 32'h3f800002},
        // 1 + 2^-30 leaves only the sticky bit
        {32'h3f800000, 32'h30800000, 32'h3f800000},
        {32'h41200000, 32'hbf800000, 32'h41100000},
        {32'h3f800000, 32'hbf400000, 32'h3e800000},
        {32'h3f800001, 32'hbf800000, 32'h34000000},
        {32'h3f800000, 32'hbf800001, 32'hb4000000},
        {32'h40490fdb, 32'hc0490fdb, 32'h00000000},
        {32'hc0400000, 32'h3f800000, 32'hc0000000},
        {32'hbf800000, 32'hbf800000, 32'hc0000000},
        {32'h7f7fffff, 32'h7f7fffff, 32'h7f800000},
        // 2^-126 - 1.5*2^-127 flushes to zero
        {32'h00800000, 32'h80400000, 32'h00000000}
    };

    fadd_unit i_fadd_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // starts at a rising edge and returns at the edge where ack is seen
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int unsigned cycles;
        logic        acked;
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdata;
        wb_sel <= 4'hf;
        cycles = 0;
        acked = 1'b0;
        while (!acked && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            acked = wb_ack;
        end
        if (!acked) begin
            $display("no ack for address %h after %0d cycles", adr, ACK_TIMEOUT);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        rdata = wb_dat_r;
    endtask

    task automatic end_cycle();
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, adr, data, unused);
        end_cycle();
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
        bus_cycle(1'b0, adr, '0, data);
        end_cycle();
    endtask

    // read starts right after the command ack while the add is in flight
    task automatic issue_and_read(input wb_addr_t adr, output wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, REG_CMD, 32'h1, unused);
        bus_cycle(1'b0, adr, '0, data);
        end_cycle();
    endtask

    initial begin
        wb_data_t rd;
        float32_t x;
        float32_t y;
        float32_t sum;
        arst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = 4'h0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        wb_read(REG_STAT, rd);
        check_value("wb_dat_r (REG_STAT after reset)", 32'h0, rd);
        wb_read(REG_RES, rd);
        check_value("wb_dat_r (REG_RES after reset)", 32'h0, rd);
        wb_write(REG_X, 32'h12345678);
        wb_write(REG_Y, 32'hcafe0001);
        wb_read(REG_X, rd);
        check_value("wb_dat_r (REG_X)", 32'h12345678, rd);
        wb_read(REG_Y, rd);
        check_value("wb_dat_r (REG_Y)", 32'hcafe0001, rd);
        wb_read(5'h14, rd);
        check_value("wb_dat_r (unmapped)", 32'h0, rd);

        for (int i = 0; i < N_VEC; i++) begin
            {x, y, sum} = vectors[i];
            wb_write(REG_X, x);
            wb_write(REG_Y, y);
            issue_and_read(REG_RES, rd);
            check_value($sformatf("wb_dat_r (REG_RES, vector %0d)", i), sum, rd);
            wb_read(REG_STAT, rd);
            check_value($sformatf("wb_dat_r (REG_STAT, vector %0d)", i), 32'h0, rd);
            issue_and_read(REG_STAT, rd);
            check_value($sformatf("wb_dat_r (REG_STAT busy, vector %0d)", i), 32'h1, rd);
            wb_read(REG_RES, rd);
            check_value($sformatf("wb_dat_r (REG_RES again, vector %0d)", i), sum, rd);
            wb_read(REG_STAT, rd);
            check_value($sformatf("wb_dat_r (REG_STAT idle, vector %0d)", i), 32'h0, rd);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
common/fp_pkg.sv
common/fadd_if.sv
fadd/lzc.sv
fadd/fadd.sv
src/fadd_wb_regs.sv
src/fadd_unit.sv
bench/fadd_unit_properties.sv
bench/fadd_unit_tb.sv

/* Bender.yml */
package:
  name: fadd_unit

sources:
  - common/fp_pkg.sv
  - common/fadd_if.sv
  - fadd/lzc.sv
  - fadd/fadd.sv
  - src/fadd_wb_regs.sv
  - src/fadd_unit.sv
  - target: test
    files:
      - bench/fadd_unit_properties.sv
      - bench/fadd_unit_tb.sv
